// File: verif/multicore_tests.txt
# T name | S in_valid io_in cycles | E core value
# S lines are applied one per clock for the given number of cycles.
T stagger_release
S 0 0 40
T single_core
E 0 -1143
S 0 0 1
S 1 999 1
S 1 100 1
S 1 -250 1
S 1 7 1
S 1 -1000 1
S 0 0 6
T weighted
E 0 6
E 1 112
E 2 138
E 3 -112
S 1 5 4
S 1 -2 10
S 1 30 10
S 1 -7 20
T collision
E 0 65
S 0 0 12
S 1 11 1
S 0 0 1
S 1 -4 1
S 0 0 2
S 1 50 1
S 0 0 1
S 1 8 1
S 0 0 20
T done_hold
E 0 12
E 1 24
E 2 36
E 3 48
S 1 3 45
T rereset
E 0 -4
E 1 -8
E 2 -12
E 3 -16
S 1 -1 45

// File: project.f
common/multicore_pkg.sv
design/reset_stagger.sv
mac_core/mac_core.sv
design/result_arbiter.sv
design/multicore.sv
verif/result_checker.sv
verif/multicore_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = multicore_tb
FILELIST = project.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))
DATA     = verif/multicore_tests.txt

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: verif/multicore_tb.sv
`timescale 1ns/10ps

module multicore_tb;

	localparam int clk_period = 100;
	localparam string tests_file = "verif/multicore_tests.txt";

	logic                                                       clk;
	logic                                                       rst;
	logic                                                       in_valid;
	logic signed [multicore_pkg::sample_w-1:0]                  io_in;
	logic                                                       result_valid;
	logic        [multicore_pkg::sel_w-1:0]                     result_core;
	logic signed [multicore_pkg::result_w-1:0]                  result_value;
	logic        [multicore_pkg::num_cores-1:0]                 core_running;
	logic [multicore_pkg::num_cores*multicore_pkg::count_w-1:0] samples_left;

	int     stim_cycles;
	int     test_total;
	int     bad_lines;
	longint limit_ns;

	initial begin
		clk = 1'b0;
	end

	always #(clk_period / 2) clk = ~clk;

	multicore u_dut (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.io_in        (io_in),
		.result_valid (result_valid),
		.result_core  (result_core),
		.result_value (result_value),
		.core_running (core_running),
		.samples_left (samples_left)
	);

	result_checker u_checker (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.result_valid (result_valid),
		.result_core  (result_core),
		.result_value (result_value),
		.core_running (core_running),
		.samples_left (samples_left)
	);

	task automatic drive_cycle(input int valid, input int data);
		in_valid <= (valid != 0);
		io_in <= multicore_pkg::sample_w'(data);
		@(posedge clk);
	endtask

	// Two edges see rst high; the first sample is then set up.
	task automatic apply_reset();
		rst <= 1'b1;
		in_valid <= 1'b0;
		io_in <= '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic finish_test();
		in_valid <= 1'b0;
		io_in <= '0;
		repeat (4) @(posedge clk);
		u_checker.end_test();
	endtask

	task automatic count_stimulus();
		int    fd;
		int    valid;
		int    data;
		int    cycles;
		string line;
		string tag;
		stim_cycles = 0;
		test_total = 0;
		fd = $fopen(tests_file, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%s %d %d %d", tag, valid, data, cycles) == 4 && tag == "S")
					stim_cycles += cycles;
				else if ($sscanf(line, "%s", tag) == 1 && tag == "T")
					test_total++;
			end
			$fclose(fd);
		end
	endtask

	task automatic run_tests();
		int    fd;
		int    valid;
		int    data;
		int    cycles;
		int    core;
		int    value;
		bit    in_test;
		string line;
		string tag;
		string name;
		in_test = 1'b0;
		fd = $fopen(tests_file, "r");
		while ($fgets(line, fd) != 0) begin
			if ($sscanf(line, "%s", tag) < 1 || tag.substr(0, 0) == "#")
				continue;
			if (tag == "T" && $sscanf(line, "%s %s", tag, name) == 2) begin
				if (in_test)
					finish_test();
				u_checker.start_test(name);
				apply_reset();
				in_test = 1'b1;
			end else if (tag == "S" && $sscanf(line, "%s %d %d %d", tag, valid, data, cycles) == 4) begin
				repeat (cycles) drive_cycle(valid, data);
			end else if (tag == "E" && $sscanf(line, "%s %d %d", tag, core, value) == 3) begin
				u_checker.push_expected(core, value);
			end else begin
				$display("Line in %s could not be understood: %s", tests_file, line);
				bad_lines++;
			end
		end
		if (in_test)
			finish_test();
		$fclose(fd);
	endtask

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		io_in = '0;
		bad_lines = 0;
		limit_ns = 0;
		count_stimulus();
		if (test_total == 0) begin
			$display("No tests could be read from %s", tests_file);
			$display("Errors found");
			$finish;
		end else begin
			limit_ns = longint'(stim_cycles + 10 * test_total) * clk_period * 2;
			run_tests();
			u_checker.final_report();
			if (u_checker.error_count == 0 && bad_lines == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

	// Watchdog sized from the stimulus length.
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Watchdog expired after %0d ns, the tests did not complete", limit_ns);
		$display("Errors found");
		$finish;
	end

endmodule

// File: verif/result_checker.sv
`timescale 1ns/10ps

module result_checker (
	input logic                                                       clk,
	input logic                                                       rst,
	input logic                                                       in_valid,
	input logic                                                       result_valid,
	input logic        [multicore_pkg::sel_w-1:0]                     result_core,
	input logic signed [multicore_pkg::result_w-1:0]                  result_value,
	input logic        [multicore_pkg::num_cores-1:0]                 core_running,
	input logic [multicore_pkg::num_cores*multicore_pkg::count_w-1:0] samples_left
);

	int    exp_core_q[$];
	int    exp_value_q[$];
	string test_name;
	int    cycle;
	int    left[multicore_pkg::num_cores];
	int    finish_edge[multicore_pkg::num_cores];
	logic  rst_d;
	logic  left_valid;
	int    test_errors;
	int    error_count;
	int    test_count;
	int    failed_count;

	initial begin
		test_name = "";
		cycle = 0;
		rst_d = 1'b0;
		left_valid = 1'b0;
		test_errors = 0;
		error_count = 0;
		test_count = 0;
		failed_count = 0;
		for (int k = 0; k < multicore_pkg::num_cores; k++) begin
			left[k] = multicore_pkg::taps;
			finish_edge[k] = -10;
		end
	end

	task automatic count_error();
		test_errors++;
		error_count++;
	endtask

	task automatic report_value(input string signal, input int expected, input int actual);
		$display("ERROR %0t %s expected %0d got %0d", $time, signal, expected, actual);
		count_error();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic push_expected(input int core, input int value);
		exp_core_q.push_back(core);
		exp_value_q.push_back(value);
	endtask

	task automatic end_test();
		if (exp_core_q.size() != 0) begin
			$display("%0d expected result(s) never arrived in test %s",
				exp_core_q.size(), test_name);
			test_errors += exp_core_q.size();
			error_count += exp_core_q.size();
			exp_core_q.delete();
			exp_value_q.delete();
		end
		test_count++;
		if (test_errors != 0) begin
			failed_count++;
			$display("test %s failed with %0d error(s)", test_name, test_errors);
		end else begin
			$display("test %s passed", test_name);
		end
	endtask

	task automatic final_report();
		$display("%0d tests run, %0d failed, %0d errors in total",
			test_count, failed_count, error_count);
	endtask

	task automatic check_result();
		int exp_core;
		int exp_value;
		if (exp_core_q.size() == 0) begin
			$display("At %0t an unexpected result came from core %0d with value %0d",
				$time, result_core, result_value);
			count_error();
		end else begin
			exp_core = exp_core_q.pop_front();
			exp_value = exp_value_q.pop_front();
			if (int'(result_core) != exp_core)
				report_value("result_core", exp_core, int'(result_core));
			if (int'(result_value) != exp_value)
				report_value("result_value", exp_value, int'(result_value));
		end
	endtask

	// Reference release count and accepted samples per core.
	// Cores only reset one edge after rst, once core_rst is high.
	always @(posedge clk) begin
		if (rst) begin
			cycle = 0;
			for (int k = 0; k < multicore_pkg::num_cores; k++) begin
				finish_edge[k] = -10;
				if (rst_d)
					left[k] = multicore_pkg::taps;
			end
			if (rst_d)
				left_valid = 1'b1;
		end else begin
			cycle = cycle + 1;
			for (int k = 0; k < multicore_pkg::num_cores; k++) begin
				if (in_valid && left[k] > 0 &&
						cycle >= 3 + multicore_pkg::stagger_cycles * k) begin
					left[k] = left[k] - 1;
					if (left[k] == 0)
						finish_edge[k] = cycle;
				end
			end
		end
		rst_d = rst;
	end

	// Outputs are compared in the middle of the cycle.
	always @(negedge clk) begin
		logic due;
		logic running_exp;
		int   field;
		due = 1'b0;
		for (int k = 0; k < multicore_pkg::num_cores; k++) begin
			running_exp = (cycle >= 1 + multicore_pkg::stagger_cycles * k);
			if (core_running[k] != running_exp)
				report_value($sformatf("core_running[%0d]", k), int'(running_exp),
					int'(core_running[k]));
			field = int'(samples_left[k*multicore_pkg::count_w +: multicore_pkg::count_w]);
			if (left_valid && field != left[k])
				report_value($sformatf("samples_left[%0d]", k), left[k], field);
			if (cycle > 0 && cycle == finish_edge[k] + 2)
				due = 1'b1;
		end
		if (result_valid != due)
			report_value("result_valid", int'(due), int'(result_valid));
		if (result_valid)
			check_result();
	end

endmodule

// File: design/multicore.sv
`timescale 1ns/10ps

module multicore (
	input  logic                                                       clk,
	input  logic                                                       rst,
	input  logic                                                       in_valid,
	input  logic signed [multicore_pkg::sample_w-1:0]                 io_in,
	output logic                                                       result_valid,
	output logic        [multicore_pkg::sel_w-1:0]                    result_core,
	output logic signed [multicore_pkg::result_w-1:0]                 result_value,
	output logic        [multicore_pkg::num_cores-1:0]                core_running,
	output logic [multicore_pkg::num_cores*multicore_pkg::count_w-1:0] samples_left
);

	logic [multicore_pkg::num_cores-1:0]                        core_rst;
	logic [multicore_pkg::num_cores-1:0]                        out_en;
	logic [multicore_pkg::num_cores*multicore_pkg::result_w-1:0] out_values;

	reset_stagger u_reset_stagger (
		.clk      (clk),
		.rst      (rst),
		.core_rst (core_rst)
	);

	assign core_running = ~core_rst;

	// Core k uses weight k + 1.
	for (genvar k = 0; k < multicore_pkg::num_cores; k++) begin : u_core
		mac_core #(
			.weight (k + 1)
		) u_mac (
			.clk          (clk),
			.rst          (core_rst[k]),
			.in_valid     (in_valid),
			.io_in        (io_in),
			.out_en       (out_en[k]),
			.out_value    (out_values[k*multicore_pkg::result_w +: multicore_pkg::result_w]),
			.samples_left (samples_left[k*multicore_pkg::count_w +: multicore_pkg::count_w])
		);
	end

	result_arbiter u_result_arbiter (
		.clk          (clk),
		.rst          (rst),
		.out_en       (out_en),
		.out_values   (out_values),
		.result_valid (result_valid),
		.result_core  (result_core),
		.result_value (result_value)
	);

endmodule

// File: design/result_arbiter.sv
`timescale 1ns/10ps

module result_arbiter (
	input  logic                                                     clk,
	input  logic                                                     rst,
	input  logic [multicore_pkg::num_cores-1:0]                      out_en,
	input  logic [multicore_pkg::num_cores*multicore_pkg::result_w-1:0] out_values,
	output logic                                                     result_valid,
	output logic        [multicore_pkg::sel_w-1:0]                   result_core,
	output logic signed [multicore_pkg::result_w-1:0]                result_value
);

	logic                                      any_en;
	logic        [multicore_pkg::sel_w-1:0]    sel;
	logic signed [multicore_pkg::result_w-1:0] sel_value;

	// Lowest index wins, so scan from the top down.
	always_comb begin
		any_en = 1'b0;
		sel = '0;
		for (int i = multicore_pkg::num_cores - 1; i >= 0; i--) begin
			if (out_en[i]) begin
				any_en = 1'b1;
				sel = multicore_pkg::sel_w'(i);
			end
		end
	end

	assign sel_value = out_values[sel*multicore_pkg::result_w +: multicore_pkg::result_w];

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= any_en;
		end
	end

	// Zero value when nothing finished.
	always_ff @(posedge clk) begin
		result_core <= sel;
		if (any_en) begin
			result_value <= sel_value;
		end else begin
			result_value <= '0;
		end
	end

endmodule

// File: mac_core/mac_core.sv
`timescale 1ns/10ps

module mac_core #(
	parameter int weight = 1
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       in_valid,
	input  logic signed [multicore_pkg::sample_w-1:0] io_in,
	output logic                                       out_en,
	output logic signed [multicore_pkg::result_w-1:0] out_value,
	output logic        [multicore_pkg::count_w-1:0]  samples_left
);

	localparam logic signed [multicore_pkg::result_w-1:0] weight_s =
		multicore_pkg::result_w'(weight);

	multicore_pkg::core_state_e state;
	multicore_pkg::core_state_e state_next;

	logic signed [multicore_pkg::result_w-1:0] acc;
	logic signed [multicore_pkg::result_w-1:0] sample_ext;
	logic signed [multicore_pkg::result_w-1:0] product;
	logic                                      take;
	logic                                      last_sample;

	// Sign extend before the multiply.
	assign sample_ext = multicore_pkg::result_w'(io_in);
	assign product = weight_s * sample_ext;

	assign take = in_valid && (state == multicore_pkg::core_collect);
	assign last_sample = (samples_left == multicore_pkg::count_w'(1));

	always_comb begin
		state_next = state;
		case (state)
			multicore_pkg::core_held: begin
				// One idle edge after release.
				state_next = multicore_pkg::core_collect;
			end
			multicore_pkg::core_collect: begin
				if (take && last_sample) begin
					state_next = multicore_pkg::core_emit;
				end
			end
			multicore_pkg::core_emit: begin
				state_next = multicore_pkg::core_done;
			end
			default: begin
				state_next = multicore_pkg::core_done;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= multicore_pkg::core_held;
			acc <= '0;
			samples_left <= multicore_pkg::count_w'(multicore_pkg::taps);
			out_en <= 1'b0;
		end else begin
			state <= state_next;
			out_en <= (state == multicore_pkg::core_emit);
			if (take) begin
				acc <= acc + product;
				samples_left <= samples_left - 1'b1;
			end
		end
	end

	// Result is latched together with the out_en pulse.
	always_ff @(posedge clk) begin
		if (state == multicore_pkg::core_emit) begin
			out_value <= acc;
		end
	end

endmodule

// File: design/reset_stagger.sv
`timescale 1ns/10ps

module reset_stagger (
	input  logic                               clk,
	input  logic                               rst,
	output logic [multicore_pkg::num_cores-1:0] core_rst
);

	logic [multicore_pkg::sel_w-1:0]     stage;
	logic [multicore_pkg::stagger_w-1:0] cycle_cnt;
	logic                                stage_last;
	logic                                interval_end;

	assign stage_last = (stage == multicore_pkg::sel_w'(multicore_pkg::num_cores - 1));
	assign interval_end =
		(cycle_cnt == multicore_pkg::stagger_w'(multicore_pkg::stagger_cycles - 1));

	// Stage advances every stagger interval, then parks on the last core.
	always_ff @(posedge clk) begin
		if (rst) begin
			stage <= '0;
			cycle_cnt <= '0;
		end else if (!stage_last) begin
			if (interval_end) begin
				stage <= stage + 1'b1;
				cycle_cnt <= '0;
			end else begin
				cycle_cnt <= cycle_cnt + 1'b1;
			end
		end
	end

	// Release the core of the current stage.
	// Released cores stay out of reset until rst.
	always_ff @(posedge clk) begin
		if (rst) begin
			core_rst <= '1;
		end else begin
			for (int k = 0; k < multicore_pkg::num_cores; k++) begin
				if (stage == multicore_pkg::sel_w'(k)) begin
					core_rst[k] <= 1'b0;
				end
			end
		end
	end

endmodule

// File: common/multicore_pkg.sv
package multicore_pkg;

	// Core array size.
	localparam int num_cores = 4;

	// Width of a core index.
	localparam int sel_w = 2;

	// Signed data widths.
	localparam int sample_w = 19;
	localparam int result_w = 28;

	// Samples summed per result.
	localparam int taps = 4;

	// Remaining-sample counter, holds 0 to taps.
	localparam int count_w = 3;

	// Cycles between successive core releases.
	localparam int stagger_cycles = 10;

	// Counter width for one stagger interval.
	localparam int stagger_w = 4;

	// Per-core control states.
	typedef enum logic [1:0] {
		core_held,
		core_collect,
		core_emit,
		core_done
	} core_state_e;

endpackage
